// File: build.f
logic/capi_rx_pkg.sv
logic/parity_tree.sv
logic/command_tag_table.sv
logic/read_data_control.sv
logic/line_assembler.sv
logic/read_data_top.sv
verif/read_data_tb_assert.sv
verif/read_data_tb.sv

// File: logic/capi_rx_pkg.sv
`default_nettype none

package capi_rx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes of one half-line
  ////////////////////////////////////////////////////////////////////////////

  localparam int DW_COUNT  = 8;                  // Doublewords per half-line
  localparam int DW_BITS   = 64;
  localparam int HALF_BITS = DW_COUNT * DW_BITS;

  // Kind of command issued under a tag
  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_READ  = 2'd1,
    CMD_WED   = 2'd2,
    CMD_WRITE = 2'd3
  } cmd_type_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] tag;
    cmd_type_t  cmd_type;
  } command_tag_t;

  // One buffer write from the host
  typedef struct packed {
    logic                 write_valid;
    logic [7:0]           write_tag;
    logic                 write_tag_parity;  // Odd
    logic [5:0]           write_address;
    logic [HALF_BITS-1:0] write_data;
    logic [DW_COUNT-1:0]  write_parity;      // Odd, one per doubleword
  } buffer_write_t;

  // Work element descriptor layout, first field in the top bits
  typedef struct packed {
    logic [63:0]  work_pointer;
    logic [31:0]  work_size;
    logic [31:0]  flags;
    logic [383:0] reserved;
  } wed_fields_t;

  typedef union packed {
    logic [DW_COUNT-1:0][DW_BITS-1:0] dw;
    wed_fields_t                      wed;
  } half_line_t;

  typedef struct packed {
    logic         valid;
    logic         read_data;
    logic         wed_data;
    command_tag_t cmd;
    half_line_t   data;
  } steer_out_t;

  typedef struct packed {
    logic                   valid;
    logic [7:0]             tag;
    logic [2*HALF_BITS-1:0] data;  // Upper half in the top 512 bits
  } full_line_t;

endpackage

`default_nettype wire

// File: logic/command_tag_table.sv
`timescale 1ns/1ns
`default_nettype none

module command_tag_table #(
  parameter int TAG_COUNT = 256
) (
  input  logic                      clock,
  input  logic                      rstn,
  input  capi_rx_pkg::command_tag_t cmd_issue,
  input  logic [7:0]                lookup_tag,
  output capi_rx_pkg::command_tag_t tag_line
);
  import capi_rx_pkg::*;

  localparam int IDX_BITS = $clog2(TAG_COUNT);

  cmd_type_t            type_mem [TAG_COUNT];
  logic [TAG_COUNT-1:0] entry_valid;
  logic [IDX_BITS-1:0]  issue_idx;
  logic [IDX_BITS-1:0]  lookup_idx;
  logic                 issue_hit;
  logic                 lookup_hit;

  assign issue_idx  = cmd_issue.tag[IDX_BITS-1:0];
  assign lookup_idx = lookup_tag[IDX_BITS-1:0];
  assign issue_hit  = cmd_issue.valid && (int'(cmd_issue.tag) < TAG_COUNT);
  assign lookup_hit = int'(lookup_tag) < TAG_COUNT;  // Tags past the table miss

  always_ff @(posedge clock) begin
    if (issue_hit) begin
      type_mem[issue_idx] <= cmd_issue.cmd_type;
    end
  end

  // Only the valid bits need clearing
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      entry_valid <= '0;
    end else if (issue_hit) begin
      entry_valid[issue_idx] <= 1'b1;
    end
  end

  // Registered lookup, lines up with the latched write
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_line <= '0;
    end else begin
      tag_line.tag <= lookup_tag;
      if (lookup_hit && entry_valid[lookup_idx]) begin
        tag_line.valid    <= 1'b1;
        tag_line.cmd_type <= type_mem[lookup_idx];
      end else begin
        tag_line.valid    <= 1'b0;
        tag_line.cmd_type <= CMD_NONE;  // Never issued
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/line_assembler.sv
`timescale 1ns/1ns
`default_nettype none

module line_assembler (
  input  logic                     clock,
  input  logic                     rstn,
  input  capi_rx_pkg::steer_out_t  steer_lo,
  input  capi_rx_pkg::steer_out_t  steer_hi,
  output capi_rx_pkg::full_line_t  line_out,
  output capi_rx_pkg::wed_fields_t wed_out,
  output logic                     wed_valid
);
  import capi_rx_pkg::*;

  steer_out_t           arrive;      // At most one side is valid per cycle
  logic                 arrive_hi;
  logic                 read_half;
  logic                 line_done;
  logic                 lo_present;
  logic                 hi_present;
  logic [HALF_BITS-1:0] lo_data;
  logic [HALF_BITS-1:0] hi_data;

  assign arrive_hi = steer_hi.valid;
  assign arrive    = arrive_hi ? steer_hi : steer_lo;
  assign read_half = arrive.valid && arrive.read_data;
  assign line_done = read_half && (arrive_hi ? lo_present : hi_present);

  ////////////////////////////////////////////////////////////////////////////
  // Read line assembly, halves in either order
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (read_half) begin
      if (arrive_hi) begin
        hi_data <= arrive.data.dw;
      end else begin
        lo_data <= arrive.data.dw;
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lo_present <= 1'b0;
      hi_present <= 1'b0;
    end else if (line_done) begin
      lo_present <= 1'b0;
      hi_present <= 1'b0;
    end else if (read_half) begin
      if (arrive_hi) begin
        hi_present <= 1'b1;
      end else begin
        lo_present <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      line_out <= '0;
    end else begin
      line_out.valid <= line_done;
      if (line_done) begin
        line_out.tag <= arrive.cmd.tag;
        if (arrive_hi) begin
          line_out.data <= {arrive.data.dw, lo_data};
        end else begin
          line_out.data <= {hi_data, arrive.data.dw};
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // WED decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wed_valid <= 1'b0;
    end else begin
      wed_valid <= arrive.valid && arrive.wed_data;
    end
  end

  always_ff @(posedge clock) begin
    if (arrive.valid && arrive.wed_data) begin
      wed_out <= arrive.data.wed;  // Descriptor view of the same bits
    end
  end

endmodule

`default_nettype wire

// File: logic/parity_tree.sv
`timescale 1ns/1ns
`default_nettype none

// Odd parity per word, so that each word plus its bit holds an odd count of ones
module parity_tree #(
  parameter int WORDS     = 8,
  parameter int WORD_BITS = 64
) (
  input  logic [WORDS*WORD_BITS-1:0] data,
  output logic [WORDS-1:0]           par
);

  always_comb begin
    for (int i = 0; i < WORDS; i++) begin
      par[i] = ~(^data[i*WORD_BITS +: WORD_BITS]);
    end
  end

endmodule

`default_nettype wire

// File: logic/read_data_control.sv
`timescale 1ns/1ns
`default_nettype none

module read_data_control (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  input  capi_rx_pkg::buffer_write_t buffer_in,
  input  capi_rx_pkg::command_tag_t  tag_line,
  output logic [1:0]                 data_read_error,
  output capi_rx_pkg::steer_out_t    steer_lo,
  output capi_rx_pkg::steer_out_t    steer_hi
);
  import capi_rx_pkg::*;

  buffer_write_t       write_q;        // Latched write with its parity bits
  logic                write_valid_q;
  logic                steer_go;
  logic                to_hi;
  steer_out_t          steer_next;
  logic                tag_par_calc;
  logic [DW_COUNT-1:0] data_par_calc;
  logic                tag_err_q;
  logic                data_err_q;

  ////////////////////////////////////////////////////////////////////////////
  // Input latch
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      write_valid_q <= 1'b0;
    end else begin
      write_valid_q <= enabled && buffer_in.write_valid;  // Drops out when disabled
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && buffer_in.write_valid) begin
      write_q <= buffer_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Steering by address and classification by command type
  ////////////////////////////////////////////////////////////////////////////

  assign steer_go = enabled && write_valid_q;
  assign to_hi    = |write_q.write_address;  // Address zero is the lower half

  always_comb begin
    steer_next         = '0;
    steer_next.valid   = 1'b1;
    steer_next.cmd     = tag_line;
    steer_next.data.dw = write_q.write_data;
    case (tag_line.cmd_type)
      CMD_READ: steer_next.read_data = 1'b1;
      CMD_WED:  steer_next.wed_data  = 1'b1;
      default:  ;                                 // Neither, dropped downstream
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      steer_lo <= '0;
      steer_hi <= '0;
    end else begin
      steer_lo <= (steer_go && !to_hi) ? steer_next : '0;
      steer_hi <= (steer_go && to_hi) ? steer_next : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parity check
  ////////////////////////////////////////////////////////////////////////////

  parity_tree #(
    .WORDS    (1),
    .WORD_BITS(8)
  ) tag_parity_i (
    .data(write_q.write_tag),
    .par (tag_par_calc)
  );

  parity_tree #(
    .WORDS    (DW_COUNT),
    .WORD_BITS(DW_BITS)
  ) data_parity_i (
    .data(write_q.write_data),
    .par (data_par_calc)
  );

  // Two stages so the error follows the steered half by one cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_err_q       <= 1'b0;
      data_err_q      <= 1'b0;
      data_read_error <= 2'b00;
    end else begin
      tag_err_q       <= steer_go && (tag_par_calc != write_q.write_tag_parity);
      data_err_q      <= steer_go && (|(data_par_calc ^ write_q.write_parity));
      data_read_error <= {data_err_q, tag_err_q};  // Bit 1 data, bit 0 tag
    end
  end

endmodule

`default_nettype wire

// File: logic/read_data_top.sv
`timescale 1ns/1ns
`default_nettype none

module read_data_top #(
  parameter int TAG_COUNT = 256
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  input  capi_rx_pkg::command_tag_t  cmd_issue,
  input  capi_rx_pkg::buffer_write_t buffer_in,
  output logic [1:0]                 data_read_error,
  output capi_rx_pkg::full_line_t    line_out,
  output capi_rx_pkg::wed_fields_t   wed_out,
  output logic                       wed_valid
);
  import capi_rx_pkg::*;

  command_tag_t tag_line;
  steer_out_t   steer_lo;
  steer_out_t   steer_hi;

  command_tag_table #(
    .TAG_COUNT(TAG_COUNT)
  ) command_tag_table_i (
    .clock     (clock),
    .rstn      (rstn),
    .cmd_issue (cmd_issue),
    .lookup_tag(buffer_in.write_tag),  // Looked up as the write is latched
    .tag_line  (tag_line)
  );

  read_data_control read_data_control_i (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .buffer_in      (buffer_in),
    .tag_line       (tag_line),
    .data_read_error(data_read_error),
    .steer_lo       (steer_lo),
    .steer_hi       (steer_hi)
  );

  line_assembler line_assembler_i (
    .clock    (clock),
    .rstn     (rstn),
    .steer_lo (steer_lo),
    .steer_hi (steer_hi),
    .line_out (line_out),
    .wed_out  (wed_out),
    .wed_valid(wed_valid)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module read_data_tb -o read_data_sim
./obj_dir/read_data_sim | tee sim.log
if grep -q "Test completed successfully" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation did not pass"
  exit 1
fi

// File: verif/read_data_tb.sv
`timescale 1ns/1ns
`default_nettype none

module read_data_tb;
  import capi_rx_pkg::*;

  localparam int TAGS = 256;

  typedef logic [1032:0] wide_t;  // Wide enough for a full line

  logic          clock;
  logic          rstn;
  logic          enabled;
  command_tag_t  cmd_issue;
  buffer_write_t buffer_in;
  logic [1:0]    data_read_error;
  full_line_t    line_out;
  wed_fields_t   wed_out;
  logic          wed_valid;

  int           seed;
  int           cyc;
  int           busy_until;
  cmd_type_t    tb_type [TAGS];  // Model of the command table
  full_line_t   exp_lines[$];
  wed_fields_t  exp_weds[$];
  logic [1:0]   err_due [int];   // Expected error bits by cycle
  bit           line_due [int];  // Cycles with a line expected
  bit           wed_due [int];   // Cycles with a WED half expected
  logic [7:0]   read_tag [4];
  logic [7:0]   wed_tag [2];
  logic [7:0]   write_tag;
  logic [7:0]   none_tag;

  read_data_top #(
    .TAG_COUNT(TAGS)
  ) read_data_top_i (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .cmd_issue      (cmd_issue),
    .buffer_in      (buffer_in),
    .data_read_error(data_read_error),
    .line_out       (line_out),
    .wed_out        (wed_out),
    .wed_valid      (wed_valid)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] odd_par(input logic [511:0] d);
    logic [7:0] p;
    for (int i = 0; i < 8; i++) begin
      p[i] = ~(^d[i*64 +: 64]);  // Ones count plus bit is odd
    end
    return p;
  endfunction

  // Bit 1 data parity, bit 0 tag parity
  function automatic logic [1:0] expect_err(input buffer_write_t w);
    return {|(odd_par(w.write_data) ^ w.write_parity), (~^w.write_tag) != w.write_tag_parity};
  endfunction

  function automatic full_line_t expect_line(input logic [7:0] tag, input logic [511:0] lo,
                                             input logic [511:0] hi);
    full_line_t l;
    l.valid = 1'b1;
    l.tag   = tag;
    l.data  = {hi, lo};
    return l;
  endfunction

  function automatic wed_fields_t expect_wed(input logic [511:0] d);
    wed_fields_t w;
    w.work_pointer = d[511:448];
    w.work_size    = d[447:416];
    w.flags        = d[415:384];
    w.reserved     = d[383:0];
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input wide_t got, input wide_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  always @(negedge clock) begin
    if (rstn) begin
      check("data_read_error", wide_t'(data_read_error),
            wide_t'(err_due.exists(cyc) ? err_due[cyc] : 2'b00));
      check("line_out.valid", wide_t'(line_out.valid), wide_t'(line_due.exists(cyc)));
      if (line_out.valid) begin
        check("line_out.tag", wide_t'(line_out.tag), wide_t'(exp_lines[0].tag));
        check("line_out.data", wide_t'(line_out.data), wide_t'(exp_lines[0].data));
        void'(exp_lines.pop_front());
      end
      check("wed_valid", wide_t'(wed_valid), wide_t'(wed_due.exists(cyc)));
      if (wed_valid) begin
        check("wed_out", wide_t'(wed_out), wide_t'(exp_weds.pop_front()));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic rand_half(output logic [511:0] d);
    for (int i = 0; i < 16; i++) begin
      d[i*32 +: 32] = $random(seed);
    end
  endtask

  task automatic issue(input logic [7:0] tag, input cmd_type_t t);
    @(negedge clock);
    cmd_issue.valid    = 1'b1;
    cmd_issue.tag      = tag;
    cmd_issue.cmd_type = t;
    tb_type[tag]       = t;
  endtask

  // flip_dw below zero leaves data parity intact
  task automatic send_half(input logic [7:0] tag, input logic [5:0] addr, input logic [511:0] d,
                           input logic flip_tag, input int flip_dw);
    buffer_write_t w;
    w.write_valid      = 1'b1;
    w.write_tag        = tag;
    w.write_tag_parity = (~^tag) ^ flip_tag;
    w.write_address    = addr;
    w.write_data       = d;
    w.write_parity     = odd_par(d);
    if (flip_dw >= 0) w.write_parity[flip_dw] = ~w.write_parity[flip_dw];
    @(negedge clock);
    buffer_in = w;
    if (enabled && expect_err(w) != 2'b00) err_due[cyc+3] = expect_err(w);
    busy_until = cyc + 4;
  endtask

  task automatic send_line(input logic [7:0] tag, input logic hi_first);
    logic [511:0] lo;
    logic [511:0] hi;
    logic [31:0]  r;
    rand_half(lo);
    rand_half(hi);
    r = $random(seed);
    if (hi_first) send_half(tag, (r[5:0] == 6'd0) ? 6'd1 : r[5:0], hi, 1'b0, -1);
    send_half(tag, 6'd0, lo, 1'b0, -1);
    if (!hi_first) send_half(tag, (r[5:0] == 6'd0) ? 6'd1 : r[5:0], hi, 1'b0, -1);
    if (enabled && tb_type[tag] == CMD_READ) begin
      exp_lines.push_back(expect_line(tag, lo, hi));
      line_due[cyc+3] = 1'b1;  // Three cycles after the second half
    end
  endtask

  task automatic send_wed(input logic [7:0] tag);
    logic [511:0] d;
    logic [31:0]  r;
    rand_half(d);
    r = $random(seed);
    send_half(tag, r[5:0], d, 1'b0, -1);
    if (enabled && tb_type[tag] == CMD_WED) begin
      exp_weds.push_back(expect_wed(d));
      wed_due[cyc+3] = 1'b1;
    end
  endtask

  task automatic wait_drained();
    int t;
    @(negedge clock);
    buffer_in.write_valid = 1'b0;  // End of the write pulse
    t = 0;
    while ((exp_lines.size() != 0 || exp_weds.size() != 0 || cyc <= busy_until) && t < 100) begin
      @(negedge clock);
      t++;
    end
    if (exp_lines.size() != 0 || exp_weds.size() != 0) begin
      abort_run($sformatf("Timed out at %0t ns waiting for expected lines or WED halves", $time));
    end
  endtask

  initial begin
    logic [31:0] r;
    seed       = 32'h2368_bd1a;
    cyc        = 0;
    busy_until = 0;
    rstn       = 1'b0;
    enabled    = 1'b0;
    cmd_issue  = '0;
    buffer_in  = '0;
    foreach (tb_type[k]) tb_type[k] = CMD_NONE;
    repeat (5) @(posedge clock);
    @(negedge clock);
    rstn    = 1'b1;
    enabled = 1'b1;

    // Tag groups kept apart by the top two bits
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      read_tag[i] = {2'b00, r[3:0], 2'(i)};
      issue(read_tag[i], CMD_READ);
    end
    for (int i = 0; i < 2; i++) begin
      r = $random(seed);
      wed_tag[i] = {2'b01, r[3:0], 2'(i)};
      issue(wed_tag[i], CMD_WED);
    end
    r = $random(seed);
    write_tag = {2'b10, r[5:0]};
    none_tag  = {2'b11, r[13:8]};
    issue(write_tag, CMD_WRITE);
    @(negedge clock);
    cmd_issue = '0;

    for (int i = 0; i < 4; i++) begin  // Single lines, halves in random order
      r = $random(seed);
      send_line(read_tag[i], r[0]);
      wait_drained();
    end
    send_wed(wed_tag[0]);
    wait_drained();
    send_wed(wed_tag[1]);
    wait_drained();

    r = $random(seed);
    send_half(write_tag, r[5:0], {16{r}}, 1'b0, int'(r[10:8]));  // Bad doubleword parity
    wait_drained();
    send_half(write_tag, r[5:0], {16{r}}, 1'b1, -1);            // Bad tag parity
    wait_drained();

    @(negedge clock);
    enabled = 1'b0;
    send_line(read_tag[0], 1'b0);
    send_wed(wed_tag[0]);
    send_half(write_tag, 6'd0, {16{r}}, 1'b1, 0);
    wait_drained();
    enabled = 1'b1;
    send_line(write_tag, 1'b0);
    send_line(none_tag, 1'b1);
    wait_drained();

    for (int i = 0; i < 4; i++) begin  // Back to back, one write per cycle
      r = $random(seed);
      send_line(read_tag[i], r[0]);
    end
    send_wed(wed_tag[1]);
    wait_drained();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/read_data_tb_assert.sv
`timescale 1ns/1ns
`default_nettype none

module read_data_control_assert (
  input logic                    clock,
  input logic                    rstn,
  input logic                    enabled,
  input capi_rx_pkg::steer_out_t steer_lo,
  input capi_rx_pkg::steer_out_t steer_hi,
  input logic [1:0]              data_read_error
);

  // Only one half is steered per cycle
  lo_hi_exclusive: assert property (@(posedge clock) disable iff (!rstn)
    !(steer_lo.valid && steer_hi.valid))
    else $error("steer_lo and steer_hi valid in the same cycle");

  class_exclusive: assert property (@(posedge clock) disable iff (!rstn)
    !(steer_lo.read_data && steer_lo.wed_data) && !(steer_hi.read_data && steer_hi.wed_data))
    else $error("half marked both read data and WED data");

  disabled_quiet: assert property (@(posedge clock) disable iff (!rstn)
    $past(!enabled, 2) |-> !steer_lo.valid && !steer_hi.valid && data_read_error == 2'b00)
    else $error("output valid two cycles after enabled was low");

endmodule

bind read_data_control read_data_control_assert control_assert_i (
  .clock          (clock),
  .rstn           (rstn),
  .enabled        (enabled),
  .steer_lo       (steer_lo),
  .steer_hi       (steer_hi),
  .data_read_error(data_read_error)
);

`default_nettype wire
